/* Makefile */
TOP := tb_mainboard

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf obj_dir

/* filelist.f */
+incdir+include
src/bus_pkg.sv
src/map_pkg.sv
src/mainboard_if.sv
src/cycle_decoder.sv
src/byte_multiplexer.sv
src/sync_ram.sv
src/read_data_merge.sv
src/mainboard_bus.sv
test/mainboard_checker.sv
test/mainboard_assert.sv
test/tb_mainboard.sv

/* include/mainboard_params.svh */
`ifndef MAINBOARD_PARAMS_SVH
`define MAINBOARD_PARAMS_SVH

// scratchpad size in 16-bit words, mirrored across 8000-83FF
`define SP_WORDS 128

// expansion memory size in bytes, at 2000-3FFF
`define EX_BYTES 8192

// clk cycles per cpu clock enable, must be 2 or more
`define CPU_CLK_DIV 4

// cpu clock enables spent on each byte of a multiplexed access
`define MPX_WAIT 2

`endif

/* src/bus_pkg.sv */
`default_nettype none

package bus_pkg;

   // cpu data word, bit 0 is the msb as on the real cpu
   typedef logic [0:15] word_t;

   // expansion bus byte
   typedef logic [0:7] byte_t;

   // cpu word address
   // the byte address is this word address with a zero appended
   typedef logic [0:14] waddr_t;

endpackage

`default_nettype wire

/* src/byte_multiplexer.sv */
`default_nettype none

`include "mainboard_params.svh"

module byte_multiplexer import bus_pkg::*; import map_pkg::*; (
   input  logic       clk,
   input  logic       reset_i,
   cpu_bus_if.mux     bus,
   input  decode_t    dec_i,
   byte_bus_if.master bb,
   output logic       busy_o,
   output word_t      data_o
);

   localparam int WAIT_W = $clog2(`MPX_WAIT + 1);

   typedef enum logic [1:0] {
      S_IDLE,
      S_ODD,
      S_EVEN,
      S_DONE
   } state_e;

   state_e            state_q;
   logic [WAIT_W-1:0] wait_q;
   logic              start;
   logic              last_wait;
   logic              odd_phase;

   assign start     = bus.memen && (dec_i.region == REGION_EXPAN);
   assign last_wait = bus.clk_en && (wait_q == WAIT_W'(`MPX_WAIT - 1));
   // odd byte first, so the address already points there while idle
   assign odd_phase = (state_q != S_EVEN);

   always_ff @(posedge clk) begin
      if (reset_i) begin
         state_q <= S_IDLE;
         wait_q  <= '0;
      end else begin
         case (state_q)
            S_IDLE: begin
               wait_q <= '0;
               if (start) begin
                  state_q <= S_ODD;
               end
            end
            S_ODD, S_EVEN: begin
               if (last_wait) begin
                  wait_q  <= '0;
                  state_q <= (state_q == S_ODD) ? S_EVEN : S_DONE;
               end else if (bus.clk_en) begin
                  wait_q <= wait_q + 1'b1;
               end
            end
            default: begin
               // ready is high here, the cpu completes on this enable
               if (bus.clk_en) begin
                  state_q <= S_IDLE;
               end
            end
         endcase
      end
   end

   // odd byte is the low half of the word, even byte the high half
   always_ff @(posedge clk) begin
      if (last_wait && (state_q == S_ODD)) begin
         data_o[8:15] <= bb.rdata;
      end
      if (last_wait && (state_q == S_EVEN)) begin
         data_o[0:7] <= bb.rdata;
      end
   end

   assign busy_o = (state_q == S_ODD) || (state_q == S_EVEN);

   // select early so the odd byte read is under way before busy rises
   assign bb.sel   = (state_q == S_IDLE) ? start : busy_o;
   assign bb.we    = bus.we;
   assign bb.addr  = {dec_i.index, odd_phase};
   assign bb.wdata = odd_phase ? bus.wdata[8:15] : bus.wdata[0:7];

endmodule

`default_nettype wire

/* src/cycle_decoder.sv */
`default_nettype none

`include "mainboard_params.svh"

module cycle_decoder import map_pkg::*; (
   input  logic       clk,
   input  logic       reset_i,
   cpu_bus_if.decoder bus,
   output decode_t    dec_o,
   output logic       sp_sel_o,
   output logic       sp_valid_o,
   output logic       mpx_valid_o
);

   localparam int CNT_W = $clog2(`CPU_CLK_DIV);

   logic [CNT_W-1:0] div_q;
   logic             en_q;

   // enable is registered, so it is decoded one count early
   always_ff @(posedge clk) begin
      if (reset_i) begin
         div_q <= '0;
         en_q  <= 1'b0;
      end else begin
         en_q <= (div_q == CNT_W'(`CPU_CLK_DIV - 2));
         if (div_q == CNT_W'(`CPU_CLK_DIV - 1)) begin
            div_q <= '0;
         end else begin
            div_q <= div_q + 1'b1;
         end
      end
   end

   assign bus.clk_en = en_q;

   // byte 2000-3FFF is expansion, byte 8000-83FF is the scratchpad mirror
   always_comb begin
      dec_o.region = REGION_NONE;
      dec_o.index  = '0;
      if (bus.addr[0:2] == 3'b001) begin
         dec_o.region = REGION_EXPAN;
         dec_o.index  = bus.addr[3:14];
      end else if (bus.addr[0:5] == 6'b100000) begin
         dec_o.region = REGION_SCRATCH;
         dec_o.index  = INDEX_W'(bus.addr[8:14]);
      end
   end

   assign sp_sel_o = bus.memen && (dec_o.region == REGION_SCRATCH);

   // read data of a source is only merged while its flag is set
   always_ff @(posedge clk) begin
      if (reset_i) begin
         sp_valid_o  <= 1'b0;
         mpx_valid_o <= 1'b0;
      end else begin
         sp_valid_o  <= bus.dbin && sp_sel_o;
         mpx_valid_o <= bus.dbin && bus.memen && (dec_o.region == REGION_EXPAN);
      end
   end

endmodule

`default_nettype wire

/* src/mainboard_bus.sv */
`default_nettype none

`include "mainboard_params.svh"

module mainboard_bus import bus_pkg::*; import map_pkg::*; (
   input  logic   clk,
   input  logic   reset_i,
   input  logic   memen_i,
   input  logic   we_i,
   input  logic   dbin_i,
   input  waddr_t addr_i,
   input  word_t  wdata_i,
   output word_t  rdata_o,
   output logic   ready_o,
   output logic   cpu_clk_en_o
);

   localparam int SP_AW = $clog2(`SP_WORDS);

   cpu_bus_if  cpu ();
   byte_bus_if bb ();

   decode_t dec;
   logic    sp_sel;
   logic    sp_valid;
   logic    mpx_valid;
   logic    mpx_busy;
   word_t   sp_data;
   word_t   mpx_data;

   assign cpu.memen = memen_i;
   assign cpu.we    = we_i;
   assign cpu.dbin  = dbin_i;
   assign cpu.addr  = addr_i;
   assign cpu.wdata = wdata_i;

   assign ready_o      = cpu.ready;
   assign cpu_clk_en_o = cpu.clk_en;

   cycle_decoder u_decoder (
      .clk         (clk),
      .reset_i     (reset_i),
      .bus         (cpu),
      .dec_o       (dec),
      .sp_sel_o    (sp_sel),
      .sp_valid_o  (sp_valid),
      .mpx_valid_o (mpx_valid)
   );

   byte_multiplexer u_mpx (
      .clk     (clk),
      .reset_i (reset_i),
      .bus     (cpu),
      .dec_i   (dec),
      .bb      (bb),
      .busy_o  (mpx_busy),
      .data_o  (mpx_data)
   );

   // 16-bit scratchpad on the cpu bus directly
   sync_ram #(.data_t(word_t), .DEPTH(`SP_WORDS)) u_scratch (
      .clk     (clk),
      .sel_i   (sp_sel),
      .we_i    (cpu.we),
      .addr_i  (dec.index[SP_AW-1:0]),
      .wdata_i (cpu.wdata),
      .rdata_o (sp_data)
   );

   // 8-bit expansion memory behind the multiplexer
   sync_ram #(.data_t(byte_t), .DEPTH(`EX_BYTES)) u_expan (
      .clk     (clk),
      .sel_i   (bb.sel),
      .we_i    (bb.we),
      .addr_i  (bb.addr),
      .wdata_i (bb.wdata),
      .rdata_o (bb.rdata)
   );

   read_data_merge u_merge (
      .clk         (clk),
      .reset_i     (reset_i),
      .bus         (cpu),
      .sp_valid_i  (sp_valid),
      .sp_data_i   (sp_data),
      .mpx_valid_i (mpx_valid),
      .mpx_busy_i  (mpx_busy),
      .mpx_data_i  (mpx_data),
      .rdata_o     (rdata_o)
   );

endmodule

`default_nettype wire

/* src/mainboard_if.sv */
`default_nettype none

`include "mainboard_params.svh"

// cpu side memory bus, driven from the top level ports
interface cpu_bus_if import bus_pkg::*; ();
   logic   memen;
   logic   we;
   logic   dbin;
   waddr_t addr;
   word_t  wdata;
   logic   ready;
   logic   clk_en;

   modport decoder (input memen, dbin, addr, output clk_en);
   modport mux (input memen, we, wdata, clk_en);
   modport merge (output ready);
endinterface

// 8-bit expansion bus between the multiplexer and the byte memory
interface byte_bus_if import bus_pkg::*; ();
   logic                         sel;
   logic                         we;
   logic [$clog2(`EX_BYTES)-1:0] addr;
   byte_t                        wdata;
   byte_t                        rdata;

   modport master (
      output sel, we, addr, wdata,
      input  rdata
   );

   modport slave (
      input  sel, we, addr, wdata,
      output rdata
   );
endinterface

`default_nettype wire

/* src/map_pkg.sv */
`default_nettype none

`include "mainboard_params.svh"

package map_pkg;

   // wide enough for a word index in the larger region
   localparam int INDEX_W = $clog2(`EX_BYTES) - 1;

   typedef enum logic [1:0] {
      REGION_NONE,
      REGION_SCRATCH,
      REGION_EXPAN
   } region_e;

   // scratchpad index is a word index, expansion index is a word index
   // that the multiplexer turns into two byte addresses
   typedef struct packed {
      region_e            region;
      logic [INDEX_W-1:0] index;
   } decode_t;

endpackage

`default_nettype wire

/* src/read_data_merge.sv */
`default_nettype none

module read_data_merge import bus_pkg::*; (
   input  logic     clk,
   input  logic     reset_i,
   cpu_bus_if.merge bus,
   input  logic     sp_valid_i,
   input  word_t    sp_data_i,
   input  logic     mpx_valid_i,
   input  logic     mpx_busy_i,
   input  word_t    mpx_data_i,
   output word_t    rdata_o
);

   logic mpx_ok_q;

   // multiplexer word only counts once both bytes are in
   always_ff @(posedge clk) begin
      if (reset_i) begin
         mpx_ok_q <= 1'b0;
      end else begin
         mpx_ok_q <= mpx_valid_i && !mpx_busy_i;
      end
   end

   // idle sources read as all ones, so unmapped space gives FFFF
   assign rdata_o = (sp_valid_i ? sp_data_i  : '1) &
                    (mpx_ok_q   ? mpx_data_i : '1);

   assign bus.ready = !mpx_busy_i;

endmodule

`default_nettype wire

/* src/sync_ram.sv */
`default_nettype none

module sync_ram #(
   parameter type data_t = logic [7:0],
   parameter int  DEPTH  = 256
) (
   input  logic                     clk,
   input  logic                     sel_i,
   input  logic                     we_i,
   input  logic [$clog2(DEPTH)-1:0] addr_i,
   input  data_t                    wdata_i,
   output data_t                    rdata_o
);

   data_t mem [DEPTH];

   // read returns the old word when a write hits the same address
   always_ff @(posedge clk) begin
      if (sel_i) begin
         if (we_i) begin
            mem[addr_i] <= wdata_i;
         end
         rdata_o <= mem[addr_i];
      end
   end

endmodule

`default_nettype wire

/* test/mainboard_assert.sv */
`default_nettype none

module mainboard_assert import bus_pkg::*; (
   input logic   clk,
   input logic   reset_i,
   input logic   memen_i,
   input logic   we_i,
   input logic   dbin_i,
   input waddr_t addr_i,
   input word_t  wdata_i,
   input logic   ready_i,
   input logic   clk_en_i,
   input logic   mpx_busy_i,
   input logic   sp_valid_i,
   input logic   mpx_valid_i
);

   int fail_count = 0;

   // enable is one clk wide
   assert property (@(posedge clk) disable iff (reset_i) clk_en_i |=> !clk_en_i)
      else begin
         fail_count++;
         $error("cpu clock enable high for two cycles in a row");
      end

   // cpu side only moves on an enabled edge
   assert property (@(posedge clk) disable iff (reset_i)
      !clk_en_i |=> $stable({memen_i, we_i, dbin_i, addr_i, wdata_i}))
      else begin
         fail_count++;
         $error("cpu bus inputs changed between clock enables");
      end

   // wait states only inside an access
   assert property (@(posedge clk) disable iff (reset_i) !memen_i |-> ready_i)
      else begin
         fail_count++;
         $error("ready low while the cpu has no memory access");
      end

   assert property (@(posedge clk) disable iff (reset_i) $rose(mpx_busy_i) |-> memen_i)
      else begin
         fail_count++;
         $error("multiplexer started without a memory request");
      end

   // scratchpad reads never wait
   assert property (@(posedge clk) disable iff (reset_i) sp_valid_i |-> ready_i)
      else begin
         fail_count++;
         $error("ready low during a scratchpad read");
      end

   assert property (@(posedge clk) disable iff (reset_i) $rose(mpx_valid_i) |-> mpx_busy_i)
      else begin
         fail_count++;
         $error("expansion read without a multiplexed transfer");
      end

endmodule

`default_nettype wire

/* test/mainboard_checker.sv */
`default_nettype none

`include "mainboard_params.svh"

module mainboard_checker import bus_pkg::*; import map_pkg::*; (
   input  logic   clk,
   input  logic   reset_i,
   input  logic   memen_i,
   input  logic   we_i,
   input  logic   dbin_i,
   input  waddr_t addr_i,
   input  word_t  wdata_i,
   input  word_t  rdata_i,
   input  logic   ready_i,
   input  logic   clk_en_i,
   output int     data_errs_o,
   output int     proto_errs_o
);

   word_t sp_model [`SP_WORDS];
   byte_t ex_model [`EX_BYTES];

   int   data_errs = 0;
   int   proto_errs = 0;
   int   gap = 0;
   logic seen_en = 1'b0;
   logic saw_wait = 1'b0;

   assign data_errs_o  = data_errs;
   assign proto_errs_o = proto_errs;

   // byte address ranges of the memory map
   function automatic region_e region_of(input logic [15:0] b);
      if (b >= 16'h2000 && b <= 16'h3FFF) begin
         return REGION_EXPAN;
      end
      if (b >= 16'h8000 && b <= 16'h83FF) begin
         return REGION_SCRATCH;
      end
      return REGION_NONE;
   endfunction

   // even byte is the high half of the word
   function automatic word_t model_read(input logic [15:0] b);
      case (region_of(b))
         REGION_SCRATCH: return sp_model[b[7:1]];
         REGION_EXPAN:   return {ex_model[{b[12:1], 1'b0}], ex_model[{b[12:1], 1'b1}]};
         default:        return 16'hFFFF;
      endcase
   endfunction

   task automatic model_write(input logic [15:0] b, input word_t d);
      case (region_of(b))
         REGION_SCRATCH: sp_model[b[7:1]] = d;
         REGION_EXPAN: begin
            ex_model[{b[12:1], 1'b0}] = d[0:7];
            ex_model[{b[12:1], 1'b1}] = d[8:15];
         end
         default: ;
      endcase
   endtask

   always @(posedge clk) begin : watch
      logic [15:0] b;
      word_t       want;
      b = {addr_i, 1'b0};
      if (reset_i) begin
         gap      = 0;
         seen_en  = 1'b0;
         saw_wait = 1'b0;
      end else begin
         gap = gap + 1;
         if (clk_en_i) begin
            if (seen_en && gap != `CPU_CLK_DIV) begin
               $display("cpu clock enable pulses %0d cycles apart at %0t instead of %0d",
                        gap, $time, `CPU_CLK_DIV);
               proto_errs = proto_errs + 1;
            end
            seen_en = 1'b1;
            gap     = 0;
            if (!memen_i && !ready_i) begin
               $display("ready low at %0t with no access in progress", $time);
               proto_errs = proto_errs + 1;
            end
            if (memen_i && !ready_i) begin
               saw_wait = 1'b1;
            end
            if (memen_i && ready_i) begin
               if (region_of(b) == REGION_EXPAN && !saw_wait) begin
                  $display("expansion access at %0t finished without a wait state", $time);
                  proto_errs = proto_errs + 1;
               end
               saw_wait = 1'b0;
               if (we_i) begin
                  model_write(b, wdata_i);
               end else if (dbin_i) begin
                  want = model_read(b);
                  if (rdata_i !== want) begin
                     $display("** Error at %0t: rdata_o = %h, expected %h (byte address %h)",
                              $time, rdata_i, want, b);
                     data_errs = data_errs + 1;
                  end
               end
            end
         end
      end
   end

endmodule

`default_nettype wire

/* test/tb_mainboard.sv */
`default_nettype none

module tb_mainboard import bus_pkg::*; ();

   logic   clk;
   logic   reset;
   logic   memen;
   logic   we;
   logic   dbin;
   waddr_t addr;
   word_t  wdata;
   word_t  rdata;
   logic   ready;
   logic   cpu_clk_en;

   integer      seed;
   int          data_errs;
   int          proto_errs;
   int          timeouts;
   logic [15:0] sp_written[$];
   logic [15:0] ex_written[$];

   mainboard_bus uut (
      .clk          (clk),
      .reset_i      (reset),
      .memen_i      (memen),
      .we_i         (we),
      .dbin_i       (dbin),
      .addr_i       (addr),
      .wdata_i      (wdata),
      .rdata_o      (rdata),
      .ready_o      (ready),
      .cpu_clk_en_o (cpu_clk_en)
   );

   mainboard_checker chk (
      .clk          (clk),
      .reset_i      (reset),
      .memen_i      (memen),
      .we_i         (we),
      .dbin_i       (dbin),
      .addr_i       (addr),
      .wdata_i      (wdata),
      .rdata_i      (rdata),
      .ready_i      (ready),
      .clk_en_i     (cpu_clk_en),
      .data_errs_o  (data_errs),
      .proto_errs_o (proto_errs)
   );

   bind mainboard_bus mainboard_assert u_assert (
      .clk         (clk),
      .reset_i     (reset_i),
      .memen_i     (memen_i),
      .we_i        (we_i),
      .dbin_i      (dbin_i),
      .addr_i      (addr_i),
      .wdata_i     (wdata_i),
      .ready_i     (ready_o),
      .clk_en_i    (cpu_clk_en_o),
      .mpx_busy_i  (mpx_busy),
      .sp_valid_i  (sp_valid),
      .mpx_valid_i (mpx_valid)
   );

   initial clk = 1'b0;
   always #10 clk = ~clk;

   task automatic finish_run();
      int assert_errs;
      assert_errs = uut.u_assert.fail_count;
      $display("errors: %0d data, %0d protocol, %0d assertion, %0d timeout",
               data_errs, proto_errs, assert_errs, timeouts);
      if (data_errs == 0 && proto_errs == 0 && assert_errs == 0 && timeouts == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   endtask

   task automatic report_timeout(input string what);
      timeouts = timeouts + 1;
      $display("timeout at %0t: %s", $time, what);
   endtask

   // nothing more is waited for once a wait has timed out
   task automatic wait_enable();
      int n;
      n = 0;
      if (timeouts == 0) begin
         do begin
            @(posedge clk);
            n++;
         end while (!cpu_clk_en && n < 200);
         if (!cpu_clk_en) begin
            report_timeout("no cpu clock enable within 200 cycles");
         end
      end
   endtask

   // one complete cpu access, bus goes idle on the completing edge
   task automatic do_access(input logic wr, input logic [15:0] b, input word_t d);
      int n;
      wait_enable();
      if (timeouts == 0) begin
         memen <= 1'b1;
         we    <= wr;
         dbin  <= !wr;
         addr  <= b[15:1];
         wdata <= d;
         n = 0;
         do begin
            @(posedge clk);
            n++;
         end while (!(cpu_clk_en && ready) && n < 200);
         memen <= 1'b0;
         we    <= 1'b0;
         dbin  <= 1'b0;
         if (!(cpu_clk_en && ready)) begin
            report_timeout("ready did not return within 200 cycles");
         end
      end
   endtask

   // reads only go to words written before, unmapped space takes both
   task automatic random_access();
      logic [31:0] r;
      logic [31:0] k;
      logic [15:0] b;
      logic        wr;
      int          idx;
      r  = $random(seed);
      k  = $random(seed);
      wr = r[3];
      if (r[2:0] < 3'd3) begin
         if (!wr && sp_written.size() > 0) begin
            idx   = k[31:16] % sp_written.size();
            b     = sp_written[idx];
            b[9:8] = k[1:0];
         end else begin
            wr = 1'b1;
            b  = {6'b100000, k[9:1], 1'b0};
            sp_written.push_back(b);
         end
      end else if (r[2:0] < 3'd6) begin
         if (!wr && ex_written.size() > 0) begin
            idx = k[31:16] % ex_written.size();
            b   = ex_written[idx];
         end else begin
            wr = 1'b1;
            b  = {3'b001, k[12:1], 1'b0};
            ex_written.push_back(b);
         end
      end else begin
         // 4000-7FFF or C000-FFFF
         b = {k[15], 1'b1, k[13:1], 1'b0};
      end
      do_access(wr, b, r[31:16]);
   endtask

   initial begin
      seed     = 96;
      timeouts = 0;
      reset    = 1'b1;
      memen    = 1'b0;
      we       = 1'b0;
      dbin     = 1'b0;
      addr     = '0;
      wdata    = '0;
      repeat (16) @(posedge clk);
      reset <= 1'b0;
      // idle enables, spacing and ready are watched by the checker
      repeat (5) wait_enable();
      do_access(1'b1, 16'h8302, 16'h1234);
      do_access(1'b0, 16'h8302, '0);
      do_access(1'b0, 16'h8002, '0);
      do_access(1'b0, 16'h8102, '0);
      do_access(1'b1, 16'h2ABC, 16'hA55A);
      do_access(1'b0, 16'h2ABC, '0);
      // unmapped writes that alias live words if decoded wrongly
      do_access(1'b1, 16'hA302, 16'hDEAD);
      do_access(1'b1, 16'h0ABC, 16'hBEEF);
      do_access(1'b0, 16'h4000, '0);
      do_access(1'b0, 16'h8302, '0);
      do_access(1'b0, 16'h2ABC, '0);
      repeat (300) random_access();
      repeat (4) wait_enable();
      finish_run();
   end

endmodule

`default_nettype wire
